/* Makefile */
# Verilator build and run of the accumulator unit testbench

.PHONY: sim clean

sim:
	verilator --binary --timing -Wno-fatal --top-module pdp8_acc_tb \
		-f pdp8_acc.f -o pdp8_acc_sim
	./obj_dir/pdp8_acc_sim | tee /dev/stderr | grep -q "Test completed successfully"

clean:
	rm -rf obj_dir

/* bench/pdp8_acc_properties.sv */
// concurrent checks on the done and busy strobes, bound into the accumulator unit top level
`timescale 1ns/1ps

module pdp8_acc_properties (
    input logic clk,
    input logic rst_n,
    input logic busy,
    input logic done
);

    // one commit gives exactly one done cycle
    done_single_cycle: assert property (
        @(posedge clk) disable iff (!rst_n) done |=> !done
    ) else $error("done held high for two cycles");

    done_busy_exclusive: assert property (
        @(posedge clk) disable iff (!rst_n) !(done && busy)
    ) else $error("done and busy high together");

    // busy drops at the same edge that raises done
    busy_ends_with_done: assert property (
        @(posedge clk) disable iff (!rst_n) $fell(busy) |-> $rose(done)
    ) else $error("busy fell without done rising");

endmodule

bind pdp8_acc pdp8_acc_properties u_props (
    .clk   (clk),
    .rst_n (rst_n),
    .busy  (busy),
    .done  (done)
);

/* bench/pdp8_acc_tb.sv */
// table-driven testbench for the accumulator unit; runs fixed and random rows against a model
`timescale 1ns/1ps

module pdp8_acc_tb;

    localparam int N_FIXED   = 24;
    localparam int N_MUL     = 4;
    localparam int N_SHIFT   = 6;
    localparam int N_ROWS    = N_FIXED + 5 * N_MUL + 5 * N_SHIFT;
    localparam int TIMEOUT_NS = (N_ROWS * 30 + 8 + 4) * 4;   // worst case per row plus reset

    logic                     clk;
    logic                     rst_n;
    logic                     op_valid;
    pdp8_acc_pkg::word_t      instruction;
    pdp8_acc_pkg::word_t      operand;
    pdp8_acc_pkg::acc_state_t state;
    logic                     busy;
    logic                     done;

    logic [11:0]              row_instr [N_ROWS];
    logic [11:0]              row_opnd [N_ROWS];
    pdp8_acc_pkg::acc_state_t row_exp [N_ROWS];
    string                    row_name [N_ROWS];
    integer                   seed;

    pdp8_acc UUT (
        .clk         (clk),
        .rst_n       (rst_n),
        .op_valid    (op_valid),
        .instruction (instruction),
        .operand     (operand),
        .state       (state),
        .busy        (busy),
        .done        (done)
    );

    always #2 clk = ~clk;

    initial
    begin
        #(TIMEOUT_NS);
        $display("timeout: done never arrived for the current row");
        $display("Test failed");
        $fatal(1);
    end

    function automatic pdp8_acc_pkg::acc_state_t mk_state(input logic l,
                                                         input logic [11:0] a,
                                                         input logic [11:0] m);
        pdp8_acc_pkg::acc_state_t s;
        s.link = l;
        s.ac   = a;
        s.mq   = m;
        return s;
    endfunction

    // behaviour of the ops used by the random rows
    function automatic pdp8_acc_pkg::acc_state_t ref_step(input pdp8_acc_pkg::acc_state_t s,
                                                         input logic [11:0] instr,
                                                         input logic [11:0] opnd);
        logic [11:0]        a;
        logic [11:0]        m;
        logic [12:0]        t;
        logic [23:0]        v;
        logic signed [23:0] sv;
        integer             cnt;
        a   = s.ac;
        m   = s.mq;
        cnt = (opnd & 12'h01f) + 1;
        case (instr)
            12'o7200: s.ac = 12'o0;
            12'o7421:
            begin
                s.mq = a;
                s.ac = 12'o0;
            end
            12'o7405:
            begin
                v = m * opnd + a;       // product plus old AC
                s = mk_state(1'b0, v[23:12], v[11:0]);
            end
            12'o7415:
            begin
                sv = {a, m};
                if (cnt >= 24)
                    sv = {24{a[11]}};
                else
                    sv = sv >>> cnt;
                s = mk_state(a[11], sv[23:12], sv[11:0]);
            end
            12'o7417:
            begin
                v = {a, m};
                v = (cnt >= 24) ? 24'h0 : v >> cnt;
                s = mk_state(1'b0, v[23:12], v[11:0]);
            end
            default:
            begin
                t = {s.link, a} + {1'b0, opnd};   // only TAD reaches here
                s.link = t[12];
                s.ac   = t[11:0];
            end
        endcase
        return s;
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        if (exp !== act)
        begin
            $display("mismatch %s expected %h actual %h", name, exp, act);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    task automatic set_row(input int i, input string name, input logic [11:0] instr,
                           input logic [11:0] opnd, input pdp8_acc_pkg::acc_state_t exp);
        row_name[i]  = name;
        row_instr[i] = instr;
        row_opnd[i]  = opnd;
        row_exp[i]   = exp;
    endtask

    // appends a row whose expected state comes from the model
    task automatic model_row(inout int i, input string name, input logic [11:0] instr,
                             input logic [11:0] opnd);
        set_row(i, name, instr, opnd, ref_step(row_exp[i-1], instr, opnd));
        i++;
    endtask

    task automatic build_table();
        int          i;
        logic [11:0] r;
        set_row(0, "cla", 12'o7200, 12'o0, mk_state(0, 12'o0000, 12'o0000));
        set_row(1, "cma", 12'o7040, 12'o0, mk_state(0, 12'o7777, 12'o0000));
        set_row(2, "iac carry", 12'o7001, 12'o0, mk_state(1, 12'o0000, 12'o0000));
        set_row(3, "cll", 12'o7100, 12'o0, mk_state(0, 12'o0000, 12'o0000));
        set_row(4, "cml", 12'o7020, 12'o0, mk_state(1, 12'o0000, 12'o0000));
        set_row(5, "cla cma", 12'o7240, 12'o0, mk_state(1, 12'o7777, 12'o0000));
        set_row(6, "cla cll", 12'o7300, 12'o0, mk_state(0, 12'o0000, 12'o0000));
        set_row(7, "tad", 12'o1000, 12'o1234, mk_state(0, 12'o1234, 12'o0000));
        set_row(8, "tad carry", 12'o1000, 12'o7000, mk_state(1, 12'o0234, 12'o0000));
        set_row(9, "and", 12'o0000, 12'o0077, mk_state(1, 12'o0034, 12'o0000));
        set_row(10, "rar", 12'o7010, 12'o0, mk_state(0, 12'o4016, 12'o0000));
        set_row(11, "ral", 12'o7004, 12'o0, mk_state(1, 12'o0034, 12'o0000));
        set_row(12, "rtl", 12'o7006, 12'o0, mk_state(0, 12'o0162, 12'o0000));
        set_row(13, "rtr", 12'o7012, 12'o0, mk_state(1, 12'o0034, 12'o0000));
        set_row(14, "bsw", 12'o7002, 12'o0, mk_state(1, 12'o3400, 12'o0000));
        set_row(15, "cma cml", 12'o7060, 12'o0, mk_state(0, 12'o4377, 12'o0000));
        set_row(16, "dca", 12'o3000, 12'o1111, mk_state(0, 12'o0000, 12'o0000));
        set_row(17, "tad g3", 12'o1000, 12'o5555, mk_state(0, 12'o5555, 12'o0000));
        set_row(18, "mql", 12'o7421, 12'o0, mk_state(0, 12'o0000, 12'o5555));
        set_row(19, "tad mq", 12'o1000, 12'o2222, mk_state(0, 12'o2222, 12'o5555));
        set_row(20, "mqa", 12'o7501, 12'o0, mk_state(0, 12'o7777, 12'o5555));
        set_row(21, "swp", 12'o7521, 12'o0, mk_state(0, 12'o5555, 12'o7777));
        set_row(22, "cla mqa", 12'o7701, 12'o0, mk_state(0, 12'o7777, 12'o7777));
        set_row(23, "cla mql", 12'o7621, 12'o0, mk_state(0, 12'o0000, 12'o0000));
        i = N_FIXED;
        for (int j = 0; j < N_MUL + N_SHIFT; j++)
        begin
            model_row(i, "setup cla", 12'o7200, 12'o0);
            r = $random(seed);
            model_row(i, "setup tad mq", 12'o1000, r);
            model_row(i, "setup mql", 12'o7421, 12'o0);
            r = $random(seed);
            model_row(i, "setup tad ac", 12'o1000, r);
            r = $random(seed);
            if (j < N_MUL)
                model_row(i, "mul", 12'o7405, r);
            else
            begin
                if (j < N_MUL + 2)
                    r[4:0] = 5'd23 + 5'(4 * (j - N_MUL));   // counts of 24 and 28
                if (j % 2 == 0)
                    model_row(i, "asr", 12'o7415, r);
                else
                    model_row(i, "lsr", 12'o7417, r);
            end
        end
    endtask

    task automatic run_row(input int i);
        logic eae;
        int   cycles;
        eae = (row_instr[i] == 12'o7405) || (row_instr[i] == 12'o7415) ||
              (row_instr[i] == 12'o7417);
        @(posedge clk);
        op_valid    <= 1'b1;
        instruction <= row_instr[i];
        operand     <= row_opnd[i];
        @(posedge clk);
        if (eae)
        begin
            instruction <= 12'o7200;    // issued while busy and dropped
            operand     <= 12'o0;
        end
        else
            op_valid <= 1'b0;
        @(negedge clk);
        if (eae)
        begin
            check_value({row_name[i], " busy"}, 32'd1, {31'd0, busy});
            @(posedge clk);
            op_valid <= 1'b0;
        end
        cycles = 0;
        while (!done)
        begin
            @(negedge clk);
            cycles++;
            if (eae && !done)
                check_value({row_name[i], " busy before done"}, 32'd1, {31'd0, busy});
        end
        if (!eae)
            check_value({row_name[i], " done latency"}, 32'd1, cycles);
        check_value({row_name[i], " busy at done"}, 32'd0, {31'd0, busy});
        check_value(row_name[i], 32'(row_exp[i]), 32'(state));
    endtask

    initial
    begin
        clk         = 1'b0;
        rst_n       = 1'b0;
        op_valid    = 1'b0;
        instruction = '0;
        operand     = '0;
        seed        = 32'h2456;
        build_table();
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_value("reset state", 32'd0, 32'(state));
        check_value("reset done", 32'd0, {31'd0, done});
        check_value("reset busy", 32'd0, {31'd0, busy});
        for (int i = 0; i < N_ROWS; i++)
            run_row(i);
        $display("Test completed successfully");
        $finish;
    end

endmodule

/* design/acc_regs.sv */
// output side of the accumulator unit; holds link, AC and MQ and signals each commit
`timescale 1ns/1ps

module acc_regs (
    input  logic                     clk,
    input  logic                     rst_n,
    input  pdp8_acc_pkg::result_t    single_result,
    input  pdp8_acc_pkg::result_t    eae_result,
    output pdp8_acc_pkg::acc_state_t state,
    output logic                     done
);

    pdp8_acc_pkg::acc_state_t commit_state;
    logic                     commit;

    // never both valid in one cycle
    assign commit = single_result.valid || eae_result.valid;

    always_comb
    begin
        if (single_result.valid)
            commit_state = single_result.state;
        else
            commit_state = eae_result.state;
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            state <= '0;
            done  <= 1'b0;
        end
        else
        begin
            done <= commit;         // one cycle per commit
            if (commit)
                state <= commit_state;
        end
    end

endmodule

/* design/eae_sequencer.sv */
// EAE mode A engine; runs MUL, ASR and LSR one step per clock over AC:MQ
`timescale 1ns/1ps
`include "pdp8_acc_consts.svh"

module eae_sequencer (
    input  logic                      clk,
    input  logic                      rst_n,
    input  pdp8_acc_pkg::decoded_op_t op,
    input  logic                      op_valid_q,
    input  pdp8_acc_pkg::acc_state_t  state,
    output pdp8_acc_pkg::result_t     result
);

    localparam int CW = `PDP8_CNT_W;

    logic                     launch;
    logic [5:0]               shift_cnt;   // count field plus one
    logic                     fill_ld;
    logic                     active;
    logic [CW-1:0]            cnt;         // step counter
    logic                     w_mul;
    logic                     w_fill;
    logic                     w_link;      // also the shift-in bit
    pdp8_acc_pkg::word_t      w_ac;
    pdp8_acc_pkg::word_t      w_mq;
    pdp8_acc_pkg::word_t      w_md;        // multiplicand
    pdp8_acc_pkg::word_t      addend;
    logic [0:12]              sum;
    pdp8_acc_pkg::acc_state_t nxt;

    assign launch    = op_valid_q && (op.kind != pdp8_acc_pkg::op_single);
    assign shift_cnt = {1'b0, op.operand[7:11]} + 6'd1;
    assign fill_ld   = (op.kind != pdp8_acc_pkg::op_mul) && (shift_cnt >= `PDP8_SHIFT_FILL);

    // one step of the current operation
    always_comb
    begin
        addend = w_mq[11] ? w_md : '0;      // multiplier lsb selects add
        sum    = {1'b0, w_ac} + {1'b0, addend};
        nxt.link = w_link;
        if (w_fill)
        begin
            nxt.ac = {`PDP8_WORD_W{w_link}};
            nxt.mq = {`PDP8_WORD_W{w_link}};
        end
        else if (w_mul)
            {nxt.ac, nxt.mq} = {sum, w_mq[0:10]};
        else
            {nxt.ac, nxt.mq} = {w_link, w_ac, w_mq[0:10]};
    end

    assign result.valid = active && (cnt == CW'(1));   // last step
    assign result.state = nxt;

    // working registers
    always_ff @(posedge clk)
    begin
        if (launch)
        begin
            w_mul  <= (op.kind == pdp8_acc_pkg::op_mul);
            w_fill <= fill_ld;
            w_ac   <= state.ac;
            w_mq   <= state.mq;
            w_md   <= op.operand;
            // ASR shifts in the sign, MUL and LSR shift in zero
            w_link <= (op.kind == pdp8_acc_pkg::op_asr) ? state.ac[0] : 1'b0;
        end
        else if (active)
        begin
            w_ac   <= nxt.ac;
            w_mq   <= nxt.mq;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            active <= 1'b0;
            cnt    <= '0;
        end
        else if (launch)
        begin
            active <= 1'b1;
            if (op.kind == pdp8_acc_pkg::op_mul)
                cnt <= CW'(`PDP8_MUL_STEPS);
            else if (fill_ld)
                cnt <= CW'(1);                  // fill in a single step
            else
                cnt <= shift_cnt[CW-1:0];
        end
        else if (active)
        begin
            cnt <= cnt - CW'(1);
            if (cnt == CW'(1))
                active <= 1'b0;
        end
    end

endmodule

/* design/instr_decoder.sv */
// input side of the accumulator unit; registers issued instructions and owns the busy flag
`timescale 1ns/1ps
`include "pdp8_acc_consts.svh"

module instr_decoder (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     op_valid,
    input  pdp8_acc_pkg::word_t      instruction,
    input  pdp8_acc_pkg::word_t      operand,
    input  logic                     eae_finish,    // sequencer result valid
    output pdp8_acc_pkg::decoded_op_t op,
    output logic                     op_valid_q,
    output logic                     busy
);

    pdp8_acc_pkg::op_kind_t kind;
    pdp8_acc_pkg::word_t    eae_code;
    logic                   group3;
    logic                   accept;

    assign accept = op_valid && !busy;      // dropped while EAE runs

    // group 3 is OPR with bits 3 and 11 set
    assign group3 = (instruction[0:2] == `PDP8_OP_OPR) &&
                    instruction[`PDP8_B_GRP] && instruction[`PDP8_B_G3];

    assign eae_code = instruction & `PDP8_EAE_MASK;

    always_comb
    begin
        kind = pdp8_acc_pkg::op_single;
        if (group3)
        begin
            case (eae_code)
                `PDP8_EAE_MUL: kind = pdp8_acc_pkg::op_mul;
                `PDP8_EAE_ASR: kind = pdp8_acc_pkg::op_asr;
                `PDP8_EAE_LSR: kind = pdp8_acc_pkg::op_lsr;
                default:       kind = pdp8_acc_pkg::op_single;
            endcase
        end
    end

    // record payload, only meaningful with op_valid_q
    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            op.kind        <= kind;
            op.instruction <= instruction;
            op.operand     <= operand;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            op_valid_q <= 1'b0;
            busy       <= 1'b0;
        end
        else
        begin
            op_valid_q <= accept;
            if (eae_finish)
                busy <= 1'b0;       // falls as done rises
            else if (accept && kind != pdp8_acc_pkg::op_single)
                busy <= 1'b1;
        end
    end

endmodule

/* design/operate_unit.sv */
// single-cycle execution of memory-reference, group 1 and group 3 instructions
`timescale 1ns/1ps
`include "pdp8_acc_consts.svh"

module operate_unit (
    input  pdp8_acc_pkg::decoded_op_t op,
    input  logic                      op_valid_q,
    input  pdp8_acc_pkg::acc_state_t  state,
    output pdp8_acc_pkg::result_t     result
);

    pdp8_acc_pkg::word_t ir;
    pdp8_acc_pkg::word_t md;
    pdp8_acc_pkg::word_t a;
    logic [0:12]         la;        // link:ac for adds and rotates
    logic [2:0]          rot;

    assign ir  = op.instruction;
    assign md  = op.operand;
    assign rot = {ir[`PDP8_B_RAR], ir[`PDP8_B_RAL], ir[`PDP8_B_TWO]};

    assign result.valid = op_valid_q && (op.kind == pdp8_acc_pkg::op_single);

    always_comb
    begin
        la = {state.link, state.ac};
        a  = state.ac;
        result.state = state;           // unsupported opcodes leave state alone

        case (ir[0:2])
            `PDP8_OP_AND:
                result.state.ac = state.ac & md;
            `PDP8_OP_TAD:
            begin
                la = la + {1'b0, md};   // carry lands in link
                {result.state.link, result.state.ac} = la;
            end
            `PDP8_OP_DCA:
                result.state.ac = '0;   // memory write happens outside
            `PDP8_OP_OPR:
            begin
                if (!ir[`PDP8_B_GRP])
                begin
                    // group 1, clears before complements
                    if (ir[`PDP8_B_CLA])
                        la[1:12] = '0;
                    if (ir[`PDP8_B_CLL])
                        la[0] = 1'b0;
                    if (ir[`PDP8_B_CMA])
                        la[1:12] = ~la[1:12];
                    if (ir[`PDP8_B_CML])
                        la[0] = ~la[0];
                    if (ir[`PDP8_B_G3])
                        la = la + 13'd1;    // IAC
                    case (rot)
                        3'b001: la = {la[0], la[7:12], la[1:6]};   // BSW, link kept
                        3'b010: la = {la[1:12], la[0]};            // RAL
                        3'b011: la = {la[2:12], la[0:1]};          // RTL
                        3'b100: la = {la[12], la[0:11]};           // RAR
                        3'b101: la = {la[11:12], la[0:10]};        // RTR
                        default: la = la;                          // no rotate
                    endcase
                    {result.state.link, result.state.ac} = la;
                end
                else if (ir[`PDP8_B_G3])
                begin
                    // group 3, CLA first then MQA/MQL
                    if (ir[`PDP8_B_CLA])
                        a = '0;
                    result.state.ac = (ir[`PDP8_B_MQL] ? '0 : a) |
                                      (ir[`PDP8_B_MQA] ? state.mq : '0);
                    if (ir[`PDP8_B_MQL])
                        result.state.mq = a;
                end
            end
            default:
                result.state = state;
        endcase
    end

endmodule

/* design/pdp8_acc.sv */
// top level of the PDP-8/e style accumulator unit with its EAE
`timescale 1ns/1ps

module pdp8_acc (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     op_valid,
    input  pdp8_acc_pkg::word_t      instruction,
    input  pdp8_acc_pkg::word_t      operand,
    output pdp8_acc_pkg::acc_state_t state,
    output logic                     busy,
    output logic                     done
);

    pdp8_acc_pkg::decoded_op_t op;
    logic                      op_valid_q;
    pdp8_acc_pkg::result_t     single_result;
    pdp8_acc_pkg::result_t     eae_result;

    instr_decoder u_decoder (
        .clk         (clk),
        .rst_n       (rst_n),
        .op_valid    (op_valid),
        .instruction (instruction),
        .operand     (operand),
        .eae_finish  (eae_result.valid),
        .op          (op),
        .op_valid_q  (op_valid_q),
        .busy        (busy)
    );

    operate_unit u_operate (
        .op          (op),
        .op_valid_q  (op_valid_q),
        .state       (state),
        .result      (single_result)
    );

    eae_sequencer u_eae (
        .clk         (clk),
        .rst_n       (rst_n),
        .op          (op),
        .op_valid_q  (op_valid_q),
        .state       (state),
        .result      (eae_result)
    );

    acc_regs u_regs (
        .clk           (clk),
        .rst_n         (rst_n),
        .single_result (single_result),
        .eae_result    (eae_result),
        .state         (state),
        .done          (done)
    );

endmodule

/* design/pdp8_acc_consts.svh */
// shared widths, opcode fields and EAE limits for the accumulator unit, included where needed
`ifndef PDP8_ACC_CONSTS_SVH
`define PDP8_ACC_CONSTS_SVH

`define PDP8_WORD_W     12      // machine word, bit 0 is the msb
`define PDP8_CNT_W      5       // EAE step counter width
`define PDP8_SHIFT_FILL 24      // shifts of this many or more just fill
`define PDP8_MUL_STEPS  12      // one step per multiplier bit

// major opcodes, instruction[0:2]
`define PDP8_OP_AND     3'o0
`define PDP8_OP_TAD     3'o1
`define PDP8_OP_DCA     3'o3
`define PDP8_OP_OPR     3'o7

// operate microinstruction bits
`define PDP8_B_GRP      3       // 0 selects group 1
`define PDP8_B_CLA      4
`define PDP8_B_CLL      5       // group 1
`define PDP8_B_MQA      5       // group 3
`define PDP8_B_CMA      6
`define PDP8_B_CML      7       // group 1
`define PDP8_B_MQL      7       // group 3
`define PDP8_B_RAR      8
`define PDP8_B_RAL      9
`define PDP8_B_TWO      10      // rotate twice, or byte swap alone
`define PDP8_B_G3       11      // IAC in group 1, group 3 marker otherwise

// group 3 EAE codes, compared after masking
`define PDP8_EAE_MASK   12'o7417
`define PDP8_EAE_MUL    12'o7405
`define PDP8_EAE_ASR    12'o7415
`define PDP8_EAE_LSR    12'o7417

`endif

/* design/pdp8_acc_pkg.sv */
// types shared by the accumulator unit modules, referenced with pdp8_acc_pkg:: scoped names
`include "pdp8_acc_consts.svh"

package pdp8_acc_pkg;

    // PDP-8 numbering, msb is bit 0
    typedef logic [0:`PDP8_WORD_W-1] word_t;

    // architectural state
    typedef struct packed {
        logic  link;
        word_t ac;
        word_t mq;
    } acc_state_t;

    // how an issued instruction is executed
    typedef enum logic [1:0] {
        op_single,      // one cycle in the operate unit
        op_mul,
        op_asr,
        op_lsr
    } op_kind_t;

    // registered record handed from decode to processing
    typedef struct packed {
        op_kind_t kind;
        word_t    instruction;
        word_t    operand;      // memory word, multiplier or shift count
    } decoded_op_t;

    // what a processing block sends to the register file
    typedef struct packed {
        logic       valid;
        acc_state_t state;
    } result_t;

endpackage

/* pdp8_acc.f */
+incdir+design
design/pdp8_acc_pkg.sv
design/instr_decoder.sv
design/operate_unit.sv
design/eae_sequencer.sv
design/acc_regs.sv
design/pdp8_acc.sv
bench/pdp8_acc_properties.sv
bench/pdp8_acc_tb.sv
